// File: Makefile
# Verilator build and run for the video_calc testbench

TOP := tb_video_calc

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal \
		-f video_calc.f --top-module $(TOP) -o $(TOP)

# the run passes only if the log holds the pass line
run: compile
	./obj_dir/$(TOP) | tee sim.log
	grep -q "Simulation passed" sim.log

clean:
	rm -rf obj_dir sim.log

// File: design/video_calc_pkg.sv
//////////////////////////////////////////////////
// shared definitions for the video timing meter
// counter width, parameter numbers, meter states
//////////////////////////////////////////////////

package video_calc_pkg;

    // every measurement counter is one 32-bit word
    localparam int cnt_w = 32;

    // parameter numbers seen by the host on par_num
    // numbers outside this list read back as zero
    typedef enum logic [4:0] {
        PAR_NRES      = 5'd1,
        PAR_HCNT_LO   = 5'd2,
        PAR_HCNT_HI   = 5'd3,
        PAR_VCNT_LO   = 5'd4,
        PAR_VCNT_HI   = 5'd5,
        PAR_HTIME_LO  = 5'd6,
        PAR_HTIME_HI  = 5'd7,
        PAR_VTIME_LO  = 5'd8,
        PAR_VTIME_HI  = 5'd9,
        PAR_PIX_LO    = 5'd10,
        PAR_PIX_HI    = 5'd11,
        // pixel repetition and active area offsets
        PAR_PIXREP    = 5'd16,
        PAR_DE_H      = 5'd17,
        PAR_DE_V      = 5'd18
    } par_num_e;

    // pixel meter frame states
    // WAIT_VS only occurs until the first frame start after reset
    typedef enum logic [1:0] {
        MEAS_WAIT_VS = 2'd0,
        MEAS_COUNT   = 2'd1,
        MEAS_DONE    = 2'd2
    } meas_state_e;

endpackage

// File: design/video_calc_top.sv
//////////////////////////////////////////////////
// video timing measurement top level
//////////////////////////////////////////////////

`timescale 1ns/100ps

module video_calc_top #(
    parameter int nres_hold = 15
) (
    input  logic        clk_100,
    input  logic        arst_n,
    input  logic        ce_pix,
    input  logic        de,
    input  logic        hs,
    input  logic        vs,
    input  logic        new_vmode,
    input  logic        rd_strobe,
    input  logic [4:0]  par_num,
    output logic [15:0] dout,
    output logic        dout_valid
);

    logic [video_calc_pkg::cnt_w-1:0] hcnt, vcnt;
    logic [video_calc_pkg::cnt_w-1:0] htime, vtime, pix;
    logic [7:0]                      pixrep, de_v, nres;
    logic [15:0]                     de_h;

    // pixel-rate measurements, qualified by ce_pix
    video_pixel_meter #(
        .nres_hold (nres_hold)
    ) u_pixel_meter (
        .clk_100   (clk_100),
        .arst_n    (arst_n),
        .ce_pix    (ce_pix),
        .de        (de),
        .hs        (hs),
        .vs        (vs),
        .new_vmode (new_vmode),
        .hcnt      (hcnt),
        .vcnt      (vcnt),
        .pixrep    (pixrep),
        .de_h      (de_h),
        .de_v      (de_v),
        .nres      (nres)
    );

    // periods on the free-running 100 MHz base
    video_time_meter u_time_meter (
        .clk_100 (clk_100),
        .arst_n  (arst_n),
        .de      (de),
        .hs      (hs),
        .vs      (vs),
        .htime   (htime),
        .vtime   (vtime),
        .pix     (pix)
    );

    video_param_regs u_param_regs (
        .clk_100    (clk_100),
        .arst_n     (arst_n),
        .rd_strobe  (rd_strobe),
        .par_num    (par_num),
        .hcnt       (hcnt),
        .vcnt       (vcnt),
        .pixrep     (pixrep),
        .de_h       (de_h),
        .de_v       (de_v),
        .nres       (nres),
        .htime      (htime),
        .vtime      (vtime),
        .pix        (pix),
        .dout       (dout),
        .dout_valid (dout_valid)
    );

endmodule

// File: design/video_param_regs.sv
//////////////////////////////////////////////////
// host read port, one 16-bit half per par_num
//////////////////////////////////////////////////

`timescale 1ns/100ps

module video_param_regs (
    input  logic                            clk_100,
    input  logic                            arst_n,
    input  logic                            rd_strobe,
    input  logic [4:0]                      par_num,
    input  logic [video_calc_pkg::cnt_w-1:0] hcnt,
    input  logic [video_calc_pkg::cnt_w-1:0] vcnt,
    input  logic [7:0]                      pixrep,
    input  logic [15:0]                     de_h,
    input  logic [7:0]                      de_v,
    input  logic [7:0]                      nres,
    input  logic [video_calc_pkg::cnt_w-1:0] htime,
    input  logic [video_calc_pkg::cnt_w-1:0] vtime,
    input  logic [video_calc_pkg::cnt_w-1:0] pix,
    output logic [15:0]                     dout,
    output logic                            dout_valid
);

    logic [15:0] sel;

    // read mux, unknown numbers give zero
    always_comb begin
        case (video_calc_pkg::par_num_e'(par_num))
            video_calc_pkg::PAR_NRES:     sel = {8'h00, nres};
            video_calc_pkg::PAR_HCNT_LO:  sel = hcnt[15:0];
            video_calc_pkg::PAR_HCNT_HI:  sel = hcnt[31:16];
            video_calc_pkg::PAR_VCNT_LO:  sel = vcnt[15:0];
            video_calc_pkg::PAR_VCNT_HI:  sel = vcnt[31:16];
            video_calc_pkg::PAR_HTIME_LO: sel = htime[15:0];
            video_calc_pkg::PAR_HTIME_HI: sel = htime[31:16];
            video_calc_pkg::PAR_VTIME_LO: sel = vtime[15:0];
            video_calc_pkg::PAR_VTIME_HI: sel = vtime[31:16];
            video_calc_pkg::PAR_PIX_LO:   sel = pix[15:0];
            video_calc_pkg::PAR_PIX_HI:   sel = pix[31:16];
            video_calc_pkg::PAR_PIXREP:   sel = {8'h00, pixrep};
            video_calc_pkg::PAR_DE_H:     sel = de_h;
            video_calc_pkg::PAR_DE_V:     sel = {8'h00, de_v};
            default:                      sel = 16'h0000;
        endcase
    end

    //////////////////////////////////////////////////
    // one result per strobe, always on the following cycle
    always_ff @(posedge clk_100 or negedge arst_n) begin
        if (!arst_n) begin
            dout_valid <= 1'b0;
            dout       <= 16'h0000;
        end else begin
            dout_valid <= rd_strobe;
            if (rd_strobe) begin
                dout <= sel;
            end
        end
    end

endmodule

// File: design/video_pixel_meter.sv
//////////////////////////////////////////////////
// per-frame pixel meter on ce_pix: active size,
// pixel repetition, active offsets, mode changes
//////////////////////////////////////////////////

`timescale 1ns/100ps

module video_pixel_meter #(
    parameter int nres_hold = 15
) (
    input  logic                            clk_100,
    input  logic                            arst_n,
    input  logic                            ce_pix,
    input  logic                            de,
    input  logic                            hs,
    input  logic                            vs,
    input  logic                            new_vmode,
    output logic [video_calc_pkg::cnt_w-1:0] hcnt,
    output logic [video_calc_pkg::cnt_w-1:0] vcnt,
    output logic [7:0]                      pixrep,
    output logic [15:0]                     de_h,
    output logic [7:0]                      de_v,
    output logic [7:0]                      nres
);

    localparam int hold_w = $clog2(nres_hold + 1);

    video_calc_pkg::meas_state_e meas_state;

    logic                            old_vs, old_hs, old_de;
    logic                            hs_d, de_d;
    logic                            vs_fall, vs_rise, hs_fall_ce, de_rise_ce;
    logic                            hs_fall, de_rise;
    logic [video_calc_pkg::cnt_w-1:0] hcnt_cur, vcnt_cur;
    logic [7:0]                      pcnt, pixrep_cur;
    logic [15:0]                     de_h_run, de_h_cur;
    logic [7:0]                      de_v_run, de_v_cur;
    logic                            first_h, first_v;
    logic                            old_vmode, changed;
    logic [hold_w-1:0]               stab_cnt;

    //////////////////////////////////////////////////
    // edges seen at the pixel rate and at clk_100
    assign vs_fall    = ce_pix & old_vs & ~vs;
    assign vs_rise    = ce_pix & ~old_vs & vs;
    assign hs_fall_ce = ce_pix & old_hs & ~hs;
    assign de_rise_ce = ce_pix & ~old_de & de;
    assign hs_fall    = hs_d & ~hs;
    assign de_rise    = ~de_d & de;

    always_ff @(posedge clk_100 or negedge arst_n) begin
        if (!arst_n) begin
            old_vs   <= 1'b0;
            old_hs   <= 1'b0;
            old_de   <= 1'b0;
            hs_d     <= 1'b0;
            de_d     <= 1'b0;
            pcnt     <= 8'd0;
            de_h_run <= 16'd0;
        end else begin
            hs_d <= hs;
            de_d <= de;
            // pcnt holds the clk_100 distance between ce_pix pulses
            pcnt <= ce_pix ? 8'd1 : pcnt + 8'd1;
            de_h_run <= hs_fall ? 16'd1 : de_h_run + 16'd1;
            if (ce_pix) begin
                old_vs <= vs;
                old_hs <= hs;
                old_de <= de;
            end
        end
    end

    //////////////////////////////////////////////////
    // frame FSM, counting ends at the vs rise after the active area
    always_ff @(posedge clk_100 or negedge arst_n) begin
        if (!arst_n) begin
            meas_state <= video_calc_pkg::MEAS_WAIT_VS;
        end else begin
            case (meas_state)
                video_calc_pkg::MEAS_WAIT_VS:
                    if (vs_fall) meas_state <= video_calc_pkg::MEAS_COUNT;
                video_calc_pkg::MEAS_COUNT:
                    if (vs_rise) meas_state <= video_calc_pkg::MEAS_DONE;
                video_calc_pkg::MEAS_DONE:
                    if (vs_fall) meas_state <= video_calc_pkg::MEAS_COUNT;
                default:
                    meas_state <= video_calc_pkg::MEAS_WAIT_VS;
            endcase
        end
    end

    // working counts for the frame in progress
    always_ff @(posedge clk_100 or negedge arst_n) begin
        if (!arst_n) begin
            hcnt_cur   <= '0;
            vcnt_cur   <= '0;
            pixrep_cur <= 8'd0;
            de_h_cur   <= 16'd0;
            de_v_run   <= 8'd0;
            de_v_cur   <= 8'd0;
            first_h    <= 1'b0;
            first_v    <= 1'b0;
        end else if (vs_fall) begin
            hcnt_cur <= '0;
            vcnt_cur <= '0;
            de_v_run <= 8'd0;
            first_h  <= 1'b1;
            first_v  <= 1'b1;
        end else if (meas_state == video_calc_pkg::MEAS_COUNT) begin
            if (ce_pix && de) begin
                hcnt_cur   <= hcnt_cur + 1'b1;
                pixrep_cur <= pcnt;
            end
            if (de_rise_ce) vcnt_cur <= vcnt_cur + 1'b1;
            if (hs_fall_ce) de_v_run <= de_v_run + 8'd1;
            // offsets are taken from the first active line only
            if (de_rise_ce && first_v) begin
                de_v_cur <= de_v_run;
                first_v  <= 1'b0;
            end
            if (de_rise && first_h) begin
                de_h_cur <= de_h_run;
                first_h  <= 1'b0;
            end
        end
    end

    //////////////////////////////////////////////////
    // publish at frame start and track mode stability
    assign changed = (hcnt_cur != hcnt) || (vcnt_cur != vcnt) || (new_vmode != old_vmode);

    always_ff @(posedge clk_100 or negedge arst_n) begin
        if (!arst_n) begin
            hcnt      <= '0;
            vcnt      <= '0;
            pixrep    <= 8'd0;
            de_h      <= 16'd0;
            de_v      <= 8'd0;
            nres      <= 8'd0;
            old_vmode <= 1'b0;
            stab_cnt  <= '0;
        end else if (vs_fall && meas_state == video_calc_pkg::MEAS_DONE &&
                     hcnt_cur != '0 && vcnt_cur != '0) begin
            hcnt      <= hcnt_cur;
            vcnt      <= vcnt_cur;
            pixrep    <= pixrep_cur;
            de_h      <= de_h_cur;
            de_v      <= de_v_cur;
            old_vmode <= new_vmode;
            // a new mode is reported once it has held for nres_hold frames
            if (changed) begin
                stab_cnt <= hold_w'(1);
            end else if (stab_cnt != '0) begin
                if (stab_cnt == hold_w'(nres_hold)) begin
                    nres     <= nres + 8'd1;
                    stab_cnt <= '0;
                end else begin
                    stab_cnt <= stab_cnt + 1'b1;
                end
            end
        end
    end

endmodule

// File: design/video_time_meter.sv
//////////////////////////////////////////////////
// line and frame periods in clk_100 cycles, and
// active pixels per frame counted on the time base
//////////////////////////////////////////////////

`timescale 1ns/100ps

module video_time_meter (
    input  logic                            clk_100,
    input  logic                            arst_n,
    input  logic                            de,
    input  logic                            hs,
    input  logic                            vs,
    output logic [video_calc_pkg::cnt_w-1:0] htime,
    output logic [video_calc_pkg::cnt_w-1:0] vtime,
    output logic [video_calc_pkg::cnt_w-1:0] pix
);

    logic                            vs_d1, vs_d2;
    logic                            hs_d1, hs_d2;
    logic                            de_d1, de_d2;
    logic                            vs_rise, vs_fall, hs_rise;
    logic                            calc;
    logic [video_calc_pkg::cnt_w-1:0] htime_run, vtime_run, pix_run;

    // two-stage delay line on the syncs
    always_ff @(posedge clk_100 or negedge arst_n) begin
        if (!arst_n) begin
            vs_d1 <= 1'b0;
            vs_d2 <= 1'b0;
            hs_d1 <= 1'b0;
            hs_d2 <= 1'b0;
            de_d1 <= 1'b0;
            de_d2 <= 1'b0;
        end else begin
            vs_d1 <= vs;
            vs_d2 <= vs_d1;
            hs_d1 <= hs;
            hs_d2 <= hs_d1;
            de_d1 <= de;
            de_d2 <= de_d1;
        end
    end

    assign vs_rise = vs_d1 & ~vs_d2;
    assign vs_fall = vs_d2 & ~vs_d1;
    assign hs_rise = hs_d1 & ~hs_d2;

    //////////////////////////////////////////////////
    // free-running timers, latched and restarted on each rising edge
    always_ff @(posedge clk_100 or negedge arst_n) begin
        if (!arst_n) begin
            htime_run <= '0;
            vtime_run <= '0;
            pix_run   <= '0;
            htime     <= '0;
            vtime     <= '0;
            pix       <= '0;
            calc      <= 1'b0;
        end else begin
            htime_run <= htime_run + 1'b1;
            vtime_run <= vtime_run + 1'b1;
            // de is ignored until a whole frame is in view
            if (vs_fall) calc <= 1'b1;
            if (calc && de_d2) pix_run <= pix_run + 1'b1;

            // restart at 1 so the latched value is the full period
            if (hs_rise) begin
                htime     <= htime_run;
                htime_run <= video_calc_pkg::cnt_w'(1);
            end
            if (vs_rise) begin
                vtime     <= vtime_run;
                pix       <= pix_run;
                vtime_run <= video_calc_pkg::cnt_w'(1);
                pix_run   <= '0;
            end
        end
    end

endmodule

// File: dv/tb_checker.sv
//////////////////////////////////////////////////
// read port monitor: handshake and value compare,
// error counts and closing summary line
//////////////////////////////////////////////////

`timescale 1ns/100ps

module tb_checker (
    input  logic        clk_100,
    input  logic        arst_n,
    input  logic        rd_strobe,
    input  logic [4:0]  par_num,
    input  logic [7:0]  mode_idx,
    input  logic [15:0] exp_dout,
    input  logic [15:0] dout,
    input  logic        dout_valid,
    input  int          assert_errors,
    input  logic        run_done,
    output int          n_checked,
    output int          error_total
);

    logic        pend_valid;
    logic [15:0] pend_exp;
    logic [4:0]  pend_par;
    logic [7:0]  pend_mode;
    int          checked_cnt      = 0;
    int          value_errors     = 0;
    int          handshake_errors = 0;

    assign n_checked   = checked_cnt;
    assign error_total = value_errors + handshake_errors + assert_errors;

    // the request as the DUT samples it on the rising edge
    always_ff @(posedge clk_100 or negedge arst_n) begin
        if (!arst_n) begin
            pend_valid <= 1'b0;
            pend_exp   <= 16'h0000;
            pend_par   <= 5'd0;
            pend_mode  <= 8'd0;
        end else begin
            pend_valid <= rd_strobe;
            pend_exp   <= exp_dout;
            pend_par   <= par_num;
            pend_mode  <= mode_idx;
        end
    end

    //////////////////////////////////////////////////
    // registered outputs are stable half a cycle later
    always @(negedge clk_100) begin
        if (arst_n) begin
            if (dout_valid !== pend_valid) begin
                handshake_errors++;
                $display("ERROR: dout_valid is %b one cycle after rd_strobe was %b (mode %0d par %0d)",
                         dout_valid, pend_valid, pend_mode, pend_par);
            end
            if (pend_valid) begin
                checked_cnt++;
                if (dout_valid === 1'b1 && dout !== pend_exp) begin
                    value_errors++;
                    $display("CHECK FAILED mode %0d par %0d: expected 0x%04h, actual 0x%04h",
                             pend_mode, pend_par, pend_exp, dout);
                end
            end
        end
    end

    always @(posedge run_done) begin
        $display("summary: %0d reads checked, %0d value errors, %0d handshake errors, %0d %s",
                 checked_cnt, value_errors, handshake_errors, assert_errors,
                 "assertion failures");
    end

endmodule

// File: dv/tb_clock.sv
//////////////////////////////////////////////////
// clk_100 source and power-on reset
//////////////////////////////////////////////////

`timescale 1ns/100ps

module tb_clock (
    output logic clk_100,
    output logic arst_n
);

    initial begin
        clk_100 = 1'b0;
        forever #10 clk_100 = ~clk_100;
    end

    // reset goes low just after time zero so that its falling edge is seen
    initial begin
        arst_n = 1'b1;
        #1;
        arst_n = 1'b0;
        repeat (2) @(posedge clk_100);
        @(negedge clk_100);
        arst_n = 1'b1;
    end

endmodule

// File: dv/tb_video_calc.sv
//////////////////////////////////////////////////
// testbench top: mode table, sync generator,
// parameter reads and watchdog
//////////////////////////////////////////////////

`timescale 1ns/100ps

module tb_video_calc;

    localparam int nres_hold       = 2;
    localparam int frames_per_mode = nres_hold + 3;
    localparam int n_modes         = 4;
    localparam int n_pars          = 20;
    localparam int hs_width        = 2;
    localparam int vs_width        = 1;
    localparam int clk_period_ns   = 20;

    typedef struct packed {
        int h_act;
        int h_tot;
        int v_act;
        int v_tot;
        int h_front;
        int v_front;
        int div;
        int vmode;
    } mode_t;

    // h_act h_tot v_act v_tot h_front v_front div new_vmode
    // h_front is in pixels, so the offset in clk_100 cycles is h_front * div
    mode_t mode_tab [n_modes] = '{
        '{16, 22, 4,  8, 2, 2, 1, 0},
        '{24, 30, 6, 10, 3, 2, 2, 0},
        '{24, 30, 6, 10, 3, 2, 2, 1},
        '{10, 16, 3,  7, 1, 1, 3, 1}
    };

    logic        clk_100, arst_n;
    logic        ce_pix, de, hs, vs, new_vmode;
    logic        rd_strobe;
    logic [4:0]  par_num;
    logic [15:0] dout, exp_dout;
    logic        dout_valid, run_done;
    logic [7:0]  mode_idx;
    int          n_checked, error_total, n_issued;
    integer      seed;

    tb_clock u_clock (
        .clk_100 (clk_100),
        .arst_n  (arst_n)
    );

    video_calc_top #(
        .nres_hold (nres_hold)
    ) dut (
        .clk_100    (clk_100),
        .arst_n     (arst_n),
        .ce_pix     (ce_pix),
        .de         (de),
        .hs         (hs),
        .vs         (vs),
        .new_vmode  (new_vmode),
        .rd_strobe  (rd_strobe),
        .par_num    (par_num),
        .dout       (dout),
        .dout_valid (dout_valid)
    );

    tb_checker u_checker (
        .clk_100       (clk_100),
        .arst_n        (arst_n),
        .rd_strobe     (rd_strobe),
        .par_num       (par_num),
        .mode_idx      (mode_idx),
        .exp_dout      (exp_dout),
        .dout          (dout),
        .dout_valid    (dout_valid),
        .assert_errors (dut.u_chk.fail_cnt),
        .run_done      (run_done),
        .n_checked     (n_checked),
        .error_total   (error_total)
    );

    //////////////////////////////////////////////////
    // expected read data for one mode
    function automatic logic [15:0] expected_value(input mode_t row, input int p,
                                                   input int nres_cnt);
        logic [31:0] hcnt_e, vcnt_e, htime_e, vtime_e, pix_e;
        logic [15:0] res;
        hcnt_e  = 32'(row.h_act * row.v_act);
        vcnt_e  = 32'(row.v_act);
        htime_e = 32'(row.h_tot * row.div);
        vtime_e = htime_e * 32'(row.v_tot);
        pix_e   = hcnt_e * 32'(row.div);
        case (p)
            video_calc_pkg::PAR_NRES:     res = {8'h00, 8'(nres_cnt)};
            video_calc_pkg::PAR_HCNT_LO:  res = hcnt_e[15:0];
            video_calc_pkg::PAR_HCNT_HI:  res = hcnt_e[31:16];
            video_calc_pkg::PAR_VCNT_LO:  res = vcnt_e[15:0];
            video_calc_pkg::PAR_VCNT_HI:  res = vcnt_e[31:16];
            video_calc_pkg::PAR_HTIME_LO: res = htime_e[15:0];
            video_calc_pkg::PAR_HTIME_HI: res = htime_e[31:16];
            video_calc_pkg::PAR_VTIME_LO: res = vtime_e[15:0];
            video_calc_pkg::PAR_VTIME_HI: res = vtime_e[31:16];
            video_calc_pkg::PAR_PIX_LO:   res = pix_e[15:0];
            video_calc_pkg::PAR_PIX_HI:   res = pix_e[31:16];
            video_calc_pkg::PAR_PIXREP:   res = 16'(row.div);
            video_calc_pkg::PAR_DE_H:     res = 16'(row.h_front * row.div);
            video_calc_pkg::PAR_DE_V:     res = 16'(row.v_front);
            default:                      res = 16'h0000;
        endcase
        return res;
    endfunction

    // hs closes each line and vs closes each frame, so both fall at pixel 0
    task automatic drive_frames(input mode_t row);
        int f, y, x, c;
        for (f = 0; f < frames_per_mode; f++) begin
            for (y = 0; y < row.v_tot; y++) begin
                for (x = 0; x < row.h_tot; x++) begin
                    for (c = 0; c < row.div; c++) begin
                        @(negedge clk_100);
                        ce_pix    = (c == 0);
                        new_vmode = row.vmode[0];
                        hs        = (x >= row.h_tot - hs_width);
                        vs        = (y >= row.v_tot - vs_width);
                        de        = (y >= row.v_front) && (y < row.v_front + row.v_act) &&
                                    (x >= row.h_front) && (x < row.h_front + row.h_act);
                    end
                end
            end
        end
        @(negedge clk_100);
        ce_pix = 1'b0;
    endtask

    // strobes are issued back to back or with a random idle cycle between them
    task automatic read_params(input int m, input mode_t row, input int nres_cnt);
        int p;
        for (p = 0; p < n_pars; p++) begin
            @(negedge clk_100);
            rd_strobe = 1'b1;
            par_num   = p[4:0];
            exp_dout  = expected_value(row, p, nres_cnt);
            mode_idx  = 8'(m + 1);
            n_issued++;
            if (($random(seed) & 1) != 0) begin
                @(negedge clk_100);
                rd_strobe = 1'b0;
            end
        end
        @(negedge clk_100);
        rd_strobe = 1'b0;
    endtask

    //////////////////////////////////////////////////
    initial begin
        int m, nres_exp, prev_hcnt, prev_vcnt, prev_vmode;
        ce_pix     = 1'b0;
        de         = 1'b0;
        hs         = 1'b0;
        vs         = 1'b0;
        new_vmode  = 1'b0;
        rd_strobe  = 1'b0;
        par_num    = 5'd0;
        exp_dout   = 16'h0000;
        mode_idx   = 8'd0;
        run_done   = 1'b0;
        n_issued   = 0;
        seed       = 23;
        nres_exp   = 0;
        prev_hcnt  = 0;
        prev_vcnt  = 0;
        prev_vmode = 0;
        wait (arst_n === 1'b0);
        wait (arst_n === 1'b1);
        for (m = 0; m < n_modes; m++) begin
            // a new size or a new_vmode toggle counts as one resolution change
            if (mode_tab[m].h_act * mode_tab[m].v_act != prev_hcnt ||
                mode_tab[m].v_act != prev_vcnt || mode_tab[m].vmode != prev_vmode) begin
                nres_exp++;
            end
            drive_frames(mode_tab[m]);
            read_params(m, mode_tab[m], nres_exp);
            prev_hcnt  = mode_tab[m].h_act * mode_tab[m].v_act;
            prev_vcnt  = mode_tab[m].v_act;
            prev_vmode = mode_tab[m].vmode;
        end
        wait (n_checked == n_issued);
        @(negedge clk_100);
        run_done = 1'b1;
        #1;
        if (error_total == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // the run length follows from the mode table, with half again as margin
    initial begin
        longint limit_ns;
        int     i;
        limit_ns = 0;
        for (i = 0; i < n_modes; i++) begin
            limit_ns += longint'(frames_per_mode) * mode_tab[i].v_tot * mode_tab[i].h_tot *
                        mode_tab[i].div * clk_period_ns;
        end
        limit_ns = limit_ns * 3 / 2;
        #(limit_ns);
        $display("watchdog timeout after %0d ns, the measurement run did not finish", limit_ns);
        $display("Simulation failed");
        $finish;
    end

endmodule

// File: dv/video_calc_chk.sv
//////////////////////////////////////////////////
// concurrent assertions on the read handshake and
// the pixel meter state, bound into the top level
//////////////////////////////////////////////////

`timescale 1ns/100ps

module video_calc_chk (
    input logic       clk_100,
    input logic       arst_n,
    input logic       rd_strobe,
    input logic       dout_valid,
    input logic [1:0] meas_state
);

    int fail_cnt = 0;

    // every strobe gives a result on the next cycle
    valid_after_strobe: assert property (
        @(posedge clk_100) disable iff (!arst_n) rd_strobe |=> dout_valid
    ) else begin
        fail_cnt++;
        $error("dout_valid missing one cycle after rd_strobe");
    end

    // and no result appears without one
    no_extra_valid: assert property (
        @(posedge clk_100) disable iff (!arst_n) !rd_strobe |=> !dout_valid
    ) else begin
        fail_cnt++;
        $error("dout_valid high without a rd_strobe the cycle before");
    end

    valid_low_in_reset: assert property (
        @(posedge clk_100) !arst_n |-> !dout_valid
    ) else begin
        fail_cnt++;
        $error("dout_valid high while arst_n is low");
    end

    legal_meter_state: assert property (
        @(posedge clk_100) disable iff (!arst_n)
            meas_state inside {video_calc_pkg::MEAS_WAIT_VS, video_calc_pkg::MEAS_COUNT,
                               video_calc_pkg::MEAS_DONE}
    ) else begin
        fail_cnt++;
        $error("pixel meter state has an illegal encoding");
    end

endmodule

bind video_calc_top video_calc_chk u_chk (
    .clk_100    (clk_100),
    .arst_n     (arst_n),
    .rd_strobe  (rd_strobe),
    .dout_valid (dout_valid),
    .meas_state (u_pixel_meter.meas_state)
);

// File: video_calc.f
design/video_calc_pkg.sv
design/video_pixel_meter.sv
design/video_time_meter.sv
design/video_param_regs.sv
design/video_calc_top.sv
dv/video_calc_chk.sv
dv/tb_clock.sv
dv/tb_checker.sv
dv/tb_video_calc.sv
